//--- src/utrap_macros.svh
`ifndef UTRAP_MACROS_SVH
`define UTRAP_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths
`define UTR_SRC_NUM         22
`define UTR_CODE_W          5
`define UTR_VEC_W           4
`define UTR_CSR_ADDR_W      4
`define UTR_CSR_DATA_W      4
`define UTR_STAT_W          2
`define UTR_ENC_W           3
`define UTR_TB_WAYS         2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Trap priority codes, lower wins
`define UTR_CS_PAR_ERR      5'd1
`define UTR_FPA_RSVD_OP     5'd2
`define UTR_BUS_ERROR       5'd5
`define UTR_UNALIGN_UB_DATA 5'd6
`define UTR_TB_ERROR        5'd9
`define UTR_TB_MISS_READ    5'd10
`define UTR_TB_MISS_WRITE   5'd11
`define UTR_ACV_READ        5'd12
`define UTR_ACV_WRITE       5'd13
`define UTR_WRITE_X_PAGEBND 5'd14
`define UTR_WR_UL_X_PAGEBND 5'd15
`define UTR_UNALIGN_DATA_R  5'd16
`define UTR_UNALIGN_DATA_W  5'd17
`define UTR_UNALIGN_DATA_WU 5'd18

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register addresses and bus status codes
`define CSR_SUMMARY         4'd0
`define CSR_BUS_ERR         4'd1
`define CSR_LAST_HIT        4'd4
`define CSR_PARITY          4'd5
`define CSR_CONFIG          4'd6

`define STAT_NONEXIST       2'd0
`define STAT_UNCORR         2'd1
`define STAT_CORR           2'd2
`define STAT_OK             2'd3

`endif

//--- src/utrap_pkg.sv
`include "utrap_macros.svh"

package utrap_pkg;

    typedef logic [`UTR_CODE_W-1:0]     trap_code_t;  // Zero means no trap
    typedef logic [`UTR_VEC_W-1:0]      uvec_t;
    typedef logic [`UTR_SRC_NUM-1:0]    src_vec_t;    // Bit k carries code k+1
    typedef logic [`UTR_CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`UTR_CSR_DATA_W-1:0] csr_data_t;
    typedef logic [`UTR_STAT_W-1:0]     bus_stat_t;
    typedef logic [`UTR_ENC_W-1:0]      enc_trap_t;
    typedef logic [`UTR_TB_WAYS-1:0]    tb_hit_t;

    typedef struct packed {
        tb_hit_t    hit;
        logic [1:0] tag_perr;
        logic       data_perr;
        logic       acv;
        logic       m_bit;
        logic       write;
        logic       prefetch;
        enc_trap_t  enc_trap;
    } mem_ref_t;

    typedef struct packed {
        trap_code_t code;
        uvec_t      vector;
    } trap_t;

    typedef struct packed {
        csr_addr_t addr;
        logic      write;
        csr_data_t wdata;
    } csr_req_t;

    typedef struct packed {
        logic tb_error;
        logic ub_unal;
        logic tag1;
        logic tag0;
        logic data1;
        logic data0;
    } log_set_t;

    typedef struct packed {
        logic nonexist;
        logic uncorr;
        logic corr;
    } bus_log_t;

    typedef enum logic {IDLE, OFFER} fsm_state_t;

endpackage

//--- src/ref_check.sv
`timescale 1ns/10ps
`include "utrap_macros.svh"

module ref_check (
    input  logic                b_clk,
    input  logic                rst_n,
    input  logic                ref_valid,
    input  logic                ref_ready,
    input  utrap_pkg::mem_ref_t ref_in,
    input  logic                disable_cmi,
    output utrap_pkg::src_vec_t sources,
    output utrap_pkg::log_set_t log_cand,
    output logic                last_write,
    output logic                last_prefetch,
    output logic                hit_parity,
    output logic                fresh,
    output logic                inhibit_cmi
);

    utrap_pkg::mem_ref_t ref_q;
    logic                tb_err;
    logic                miss;
    logic                np;      // Fresh and not a prefetch
    logic                ub_unal;

    always_ff @(posedge b_clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_q <= '0;
            fresh <= 1'b0;
        end else begin
            fresh <= ref_valid & ref_ready;
            if (ref_valid && ref_ready) begin
                ref_q <= ref_in;
            end
        end
    end

    assign tb_err  = (|ref_q.tag_perr) | ref_q.data_perr | (&ref_q.hit);
    assign miss    = (ref_q.hit == '0);
    assign np      = fresh & ~ref_q.prefetch;
    // UB unaligned needs a clean single-way hit
    assign ub_unal = np & (ref_q.enc_trap == 3'd4) & ~tb_err & ~miss & ~ref_q.acv;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference trap sources
    always_comb begin
        sources = '0;
        sources[`UTR_CS_PAR_ERR - 1]      = fresh & (ref_q.enc_trap == 3'd7);
        sources[`UTR_FPA_RSVD_OP - 1]     = fresh & (ref_q.enc_trap == 3'd6);
        sources[`UTR_UNALIGN_UB_DATA - 1] = ub_unal;
        sources[`UTR_TB_ERROR - 1]        = np & tb_err;
        sources[`UTR_TB_MISS_READ - 1]    = np & miss & ~ref_q.write;
        sources[`UTR_TB_MISS_WRITE - 1]   = np & ref_q.write & (miss | ~ref_q.m_bit);
        sources[`UTR_ACV_READ - 1]        = np & ref_q.acv & ~ref_q.write;
        sources[`UTR_ACV_WRITE - 1]       = np & ref_q.acv & ref_q.write;
        sources[`UTR_WRITE_X_PAGEBND - 1] = np & (ref_q.enc_trap == 3'd2);
        sources[`UTR_WR_UL_X_PAGEBND - 1] = np & (ref_q.enc_trap == 3'd3);
        sources[`UTR_UNALIGN_DATA_R - 1]  = np & (ref_q.enc_trap == 3'd1) & ~ref_q.write;
        sources[`UTR_UNALIGN_DATA_W - 1]  = np & (ref_q.enc_trap == 3'd1) & ref_q.write;
        sources[`UTR_UNALIGN_DATA_WU - 1] = np & (ref_q.enc_trap == 3'd5) & ref_q.write;
    end

    always_comb begin
        log_cand.tb_error = np & tb_err;
        log_cand.ub_unal  = ub_unal;
        log_cand.tag1     = ref_q.tag_perr[1];
        log_cand.tag0     = ref_q.tag_perr[0];
        log_cand.data1    = ref_q.data_perr & ref_q.hit[1];  // Data parity blamed on the hit way
        log_cand.data0    = ref_q.data_perr & ref_q.hit[0];
    end

    assign last_write    = ref_q.write;
    assign last_prefetch = ref_q.prefetch;
    assign hit_parity    = ^ref_q.hit;

    // Prefetches that run into TB trouble must not reach the cache
    assign inhibit_cmi = disable_cmi |
                         (fresh & ref_q.prefetch & (ref_q.acv | tb_err | miss));

endmodule

//--- src/bus_monitor.sv
`timescale 1ns/10ps
`include "utrap_macros.svh"

module bus_monitor (
    input  logic                 b_clk,
    input  logic                 rst_n,
    input  logic                 status_valid,
    input  utrap_pkg::bus_stat_t status,
    input  logic                 last_write,
    input  logic                 last_prefetch,
    input  logic                 bus_trap_taken,
    output logic                 bus_err_pend,
    output logic                 write_bus_err,
    output utrap_pkg::bus_log_t  bus_log
);

    logic fail;

    // Nonexistent memory and uncorrectable data are failures
    assign fail = status_valid & (status != `STAT_OK) & (status != `STAT_CORR);

    always_ff @(posedge b_clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_err_pend  <= 1'b0;
            write_bus_err <= 1'b0;
            bus_log       <= '0;
        end else begin
            // Sticky until the BUS_ERROR trap is taken
            bus_err_pend  <= (fail & ~last_write & ~last_prefetch) |
                             (bus_err_pend & ~bus_trap_taken);
            write_bus_err <= fail & last_write;
            bus_log.nonexist <= status_valid & (status == `STAT_NONEXIST);
            bus_log.uncorr   <= status_valid & (status == `STAT_UNCORR);
            bus_log.corr     <= status_valid & (status == `STAT_CORR);
        end
    end

endmodule

//--- src/trap_prio.sv
`timescale 1ns/10ps
`include "utrap_macros.svh"

module trap_prio (
    input  utrap_pkg::src_vec_t sources,
    input  logic                bus_err_pend,
    output utrap_pkg::trap_t    trap
);

    utrap_pkg::src_vec_t   merged;
    utrap_pkg::trap_code_t code;
    utrap_pkg::uvec_t      vector;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Priority encoder
    always_comb begin
        merged = sources;
        merged[`UTR_BUS_ERROR - 1] = sources[`UTR_BUS_ERROR - 1] | bus_err_pend;
        code = '0;
        // Walk down so the lowest set slot is the last one written
        for (int i = `UTR_SRC_NUM - 1; i >= 0; i--) begin
            if (merged[i]) begin
                code = utrap_pkg::trap_code_t'(i + 1);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Micro vector table
    always_comb begin
        case (code)
            `UTR_CS_PAR_ERR:      vector = 4'b0000;
            `UTR_FPA_RSVD_OP:     vector = 4'b1100;
            `UTR_BUS_ERROR,
            `UTR_UNALIGN_UB_DATA,
            `UTR_TB_ERROR:        vector = 4'b1000;  // Shared error handler
            `UTR_TB_MISS_READ:    vector = 4'b1010;
            `UTR_TB_MISS_WRITE:   vector = 4'b1011;
            `UTR_ACV_READ:        vector = 4'b1110;
            `UTR_ACV_WRITE:       vector = 4'b1111;
            `UTR_WRITE_X_PAGEBND: vector = 4'b0111;
            `UTR_WR_UL_X_PAGEBND: vector = 4'b0110;
            `UTR_UNALIGN_DATA_R:  vector = 4'b0001;
            `UTR_UNALIGN_DATA_W:  vector = 4'b0101;
            `UTR_UNALIGN_DATA_WU: vector = 4'b0100;
            default:              vector = 4'b0000;
        endcase
    end

    assign trap.code   = code;
    assign trap.vector = vector;

endmodule

//--- src/utrap_fsm.sv
`timescale 1ns/10ps
`include "utrap_macros.svh"

module utrap_fsm (
    input  logic                b_clk,
    input  logic                rst_n,
    input  logic                fresh,
    input  logic                bus_err_pend,
    input  utrap_pkg::trap_t    trap,
    input  utrap_pkg::log_set_t log_cand,
    output logic                ref_ready,
    output logic                trap_valid,
    input  logic                trap_ready,
    output utrap_pkg::trap_t    trap_out,
    output utrap_pkg::log_set_t log_set,
    output logic                bus_trap_taken
);

    utrap_pkg::fsm_state_t state;
    utrap_pkg::log_set_t   log_next;
    logic                  take_new;

    assign take_new = (state == utrap_pkg::IDLE) && (trap.code != '0);

    // Only the winning code logs its detail
    always_comb begin
        log_next = '0;
        if (fresh && trap.code == `UTR_TB_ERROR) begin
            log_next         = log_cand;
            log_next.ub_unal = 1'b0;
        end else if (fresh && trap.code == `UTR_UNALIGN_UB_DATA) begin
            log_next.ub_unal = log_cand.ub_unal;
        end
    end

    always_ff @(posedge b_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= utrap_pkg::IDLE;
            log_set <= '0;
        end else begin
            log_set <= take_new ? log_next : '0;
            case (state)
                utrap_pkg::IDLE:  if (take_new) state <= utrap_pkg::OFFER;
                utrap_pkg::OFFER: if (trap_ready) state <= utrap_pkg::IDLE;
                default:          state <= utrap_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge b_clk) begin
        if (take_new) begin
            trap_out <= trap;
        end
    end

    assign trap_valid     = (state == utrap_pkg::OFFER);
    // Hold references off while a trap is about to be latched
    assign ref_ready      = (state == utrap_pkg::IDLE) & ~bus_err_pend &
                            ~(fresh & (trap.code != '0));
    assign bus_trap_taken = trap_valid & trap_ready & (trap_out.code == `UTR_BUS_ERROR);

endmodule

//--- src/err_regs.sv
`timescale 1ns/10ps
`include "utrap_macros.svh"

module err_regs (
    input  logic                 b_clk,
    input  logic                 rst_n,
    input  utrap_pkg::log_set_t  log_set,
    input  utrap_pkg::bus_log_t  bus_log,
    input  logic                 fresh,
    input  logic                 hit_parity,
    input  logic                 csr_valid,
    input  utrap_pkg::csr_req_t  csr_in,
    output utrap_pkg::csr_data_t rdata,
    output logic                 rdata_valid,
    output logic                 disable_cmi
);

    logic                 sum_bus;
    logic                 sum_tb;
    logic                 sum_ub;
    utrap_pkg::csr_data_t bus_err_q;  // nonexist, uncorr, lost, corr
    utrap_pkg::csr_data_t parity_q;   // tag1, tag0, data1, data0
    logic                 last_hit;
    logic                 bus_any;
    logic                 wr_sum;
    logic                 wr_cfg;

    assign bus_any = bus_log.nonexist | bus_log.uncorr | bus_log.corr;
    assign wr_sum  = csr_valid & csr_in.write & (csr_in.addr == `CSR_SUMMARY);
    assign wr_cfg  = csr_valid & csr_in.write & (csr_in.addr == `CSR_CONFIG);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Summary and detail logs
    always_ff @(posedge b_clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_bus     <= 1'b0;
            sum_tb      <= 1'b0;
            sum_ub      <= 1'b0;
            bus_err_q   <= '0;
            parity_q    <= '0;
            last_hit    <= 1'b0;
            disable_cmi <= 1'b0;
        end else begin
            sum_bus <= (wr_sum ? csr_in.wdata[3] : sum_bus) | bus_any;  // Set beats write
            sum_tb  <= (wr_sum ? csr_in.wdata[2] : sum_tb) | log_set.tb_error;
            sum_ub  <= (wr_sum ? csr_in.wdata[1] : sum_ub) | log_set.ub_unal;
            // Details hold only while their summary bit is set
            bus_err_q <= (sum_bus ? bus_err_q : '0) |
                         {bus_log.nonexist, bus_log.uncorr, sum_bus & bus_any, bus_log.corr};
            parity_q  <= (sum_tb ? parity_q : '0) |
                         {log_set.tag1, log_set.tag0, log_set.data1, log_set.data0};
            if (fresh) begin
                last_hit <= hit_parity;
            end
            if (wr_cfg) begin
                disable_cmi <= csr_in.wdata[0];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port
    always_ff @(posedge b_clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= csr_valid;
        end
    end

    always_ff @(posedge b_clk) begin
        if (csr_valid) begin
            case (csr_in.addr)
                `CSR_SUMMARY:  rdata <= {sum_bus, sum_tb, sum_ub, 1'b0};
                `CSR_BUS_ERR:  rdata <= bus_err_q;
                `CSR_LAST_HIT: rdata <= {3'b000, last_hit};
                `CSR_PARITY:   rdata <= parity_q;
                `CSR_CONFIG:   rdata <= {3'b000, disable_cmi};
                default:       rdata <= '0;
            endcase
        end
    end

endmodule

//--- src/utrap_top.sv
`timescale 1ns/10ps

module utrap_top (
    input  logic                 b_clk,
    input  logic                 rst_n,
    input  logic                 ref_valid,
    output logic                 ref_ready,
    input  utrap_pkg::mem_ref_t  ref_in,
    output logic                 trap_valid,
    input  logic                 trap_ready,
    output utrap_pkg::trap_t     trap_out,
    input  logic                 status_valid,
    input  utrap_pkg::bus_stat_t status,
    input  logic                 csr_valid,
    input  utrap_pkg::csr_req_t  csr_in,
    output utrap_pkg::csr_data_t rdata,
    output logic                 rdata_valid,
    output logic                 inhibit_cmi,
    output logic                 write_bus_err
);

    utrap_pkg::src_vec_t sources;
    utrap_pkg::log_set_t log_cand;
    utrap_pkg::log_set_t log_set;
    utrap_pkg::bus_log_t bus_log;
    utrap_pkg::trap_t    trap;
    logic                last_write;
    logic                last_prefetch;
    logic                hit_parity;
    logic                fresh;
    logic                disable_cmi;
    logic                bus_err_pend;
    logic                bus_trap_taken;

    ref_check ref_check_i (
        .b_clk, .rst_n, .ref_valid, .ref_ready, .ref_in, .disable_cmi,
        .sources, .log_cand, .last_write, .last_prefetch, .hit_parity,
        .fresh, .inhibit_cmi
    );

    bus_monitor bus_monitor_i (
        .b_clk, .rst_n, .status_valid, .status, .last_write, .last_prefetch,
        .bus_trap_taken, .bus_err_pend, .write_bus_err, .bus_log
    );

    trap_prio trap_prio_i (
        .sources, .bus_err_pend, .trap
    );

    utrap_fsm utrap_fsm_i (
        .b_clk, .rst_n, .fresh, .bus_err_pend, .trap, .log_cand, .ref_ready,
        .trap_valid, .trap_ready, .trap_out, .log_set, .bus_trap_taken
    );

    err_regs err_regs_i (
        .b_clk, .rst_n, .log_set, .bus_log, .fresh, .hit_parity,
        .csr_valid, .csr_in, .rdata, .rdata_valid, .disable_cmi
    );

endmodule

//--- test/utrap_assert.sv
`timescale 1ns/10ps

module utrap_assert (
    input logic             b_clk,
    input logic             rst_n,
    input logic             trap_valid,
    input logic             trap_ready,
    input utrap_pkg::trap_t trap_out,
    input logic             ref_ready,
    input logic             write_bus_err
);

    // An offered trap holds its code and vector until it is taken
    offer_hold_a: assert property (@(posedge b_clk) disable iff (!rst_n)
        trap_valid && !trap_ready |=> trap_valid && $stable(trap_out))
        else $error("trap offer changed before trap_ready");

    no_ref_during_offer_a: assert property (@(posedge b_clk) disable iff (!rst_n)
        trap_valid |-> !ref_ready)
        else $error("ref_ready high while a trap is offered");

    write_err_pulse_a: assert property (@(posedge b_clk) disable iff (!rst_n)
        write_bus_err |=> !write_bus_err)
        else $error("write_bus_err lasted more than one cycle");

endmodule

bind utrap_top utrap_assert utrap_assert_i (
    .b_clk(b_clk), .rst_n(rst_n), .trap_valid(trap_valid), .trap_ready(trap_ready),
    .trap_out(trap_out), .ref_ready(ref_ready), .write_bus_err(write_bus_err)
);

//--- test/utrap_tb.sv
`timescale 1ns/10ps
`include "utrap_macros.svh"

module utrap_tb;

    localparam int TIMEOUT    = 200;
    localparam int NUM_RANDOM = 60;

    logic                 b_clk;
    logic                 rst_n;
    logic                 ref_valid;
    logic                 ref_ready;
    utrap_pkg::mem_ref_t  ref_in;
    logic                 trap_valid;
    logic                 trap_ready;
    utrap_pkg::trap_t     trap_out;
    logic                 status_valid;
    utrap_pkg::bus_stat_t status;
    logic                 csr_valid;
    utrap_pkg::csr_req_t  csr_in;
    utrap_pkg::csr_data_t rdata;
    logic                 rdata_valid;
    logic                 inhibit_cmi;
    logic                 write_bus_err;

    utrap_pkg::trap_t     exp_q[$];     // Traps still to be offered in order
    logic [31:0]          rnd_state;
    logic [31:0]          stall_state;
    logic                 stall_en;
    int                   err_mismatch;
    int                   err_timeout;
    int                   err_other;
    logic                 m_sum_bus;    // Expected contents of the error registers
    logic                 m_sum_tb;
    logic                 m_sum_ub;
    utrap_pkg::csr_data_t m_bus;
    utrap_pkg::csr_data_t m_parity;
    logic                 m_last_hit;
    logic                 m_disable;
    utrap_pkg::mem_ref_t  last_ref;

    utrap_top utrap_i (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic utrap_pkg::mem_ref_t make_ref(input logic [1:0] hit,
            input logic [1:0] tag, input logic dp, input logic acv, input logic m,
            input logic wr, input logic pf, input logic [2:0] enc);
        utrap_pkg::mem_ref_t r;
        r.hit       = hit;
        r.tag_perr  = tag;
        r.data_perr = dp;
        r.acv       = acv;
        r.m_bit     = m;
        r.write     = wr;
        r.prefetch  = pf;
        r.enc_trap  = enc;
        return r;
    endfunction

    function automatic utrap_pkg::trap_t ref_trap(input utrap_pkg::mem_ref_t r,
            input logic fresh, input logic pend);
        utrap_pkg::trap_t t;
        logic np;
        logic tberr;
        logic miss;
        np    = fresh & ~r.prefetch;
        tberr = (r.tag_perr != 2'b00) | r.data_perr | (r.hit == 2'b11);
        miss  = (r.hit == 2'b00);
        t.code = 5'd0;
        if (fresh && r.enc_trap == 3'd7) t.code = `UTR_CS_PAR_ERR;
        else if (fresh && r.enc_trap == 3'd6) t.code = `UTR_FPA_RSVD_OP;
        else if (pend) t.code = `UTR_BUS_ERROR;
        else if (np && r.enc_trap == 3'd4 && !tberr && !miss && !r.acv)
            t.code = `UTR_UNALIGN_UB_DATA;
        else if (np && tberr) t.code = `UTR_TB_ERROR;
        else if (np && miss && !r.write) t.code = `UTR_TB_MISS_READ;
        else if (np && r.write && (miss || !r.m_bit)) t.code = `UTR_TB_MISS_WRITE;
        else if (np && r.acv) t.code = r.write ? `UTR_ACV_WRITE : `UTR_ACV_READ;
        else if (np && r.enc_trap == 3'd2) t.code = `UTR_WRITE_X_PAGEBND;
        else if (np && r.enc_trap == 3'd3) t.code = `UTR_WR_UL_X_PAGEBND;
        else if (np && r.enc_trap == 3'd1)
            t.code = r.write ? `UTR_UNALIGN_DATA_W : `UTR_UNALIGN_DATA_R;
        else if (np && r.enc_trap == 3'd5 && r.write) t.code = `UTR_UNALIGN_DATA_WU;
        case (t.code)
            5'd2:              t.vector = 4'b1100;
            5'd5, 5'd6, 5'd9:  t.vector = 4'b1000;
            5'd10:             t.vector = 4'b1010;
            5'd11:             t.vector = 4'b1011;
            5'd12:             t.vector = 4'b1110;
            5'd13:             t.vector = 4'b1111;
            5'd14:             t.vector = 4'b0111;
            5'd15:             t.vector = 4'b0110;
            5'd16:             t.vector = 4'b0001;
            5'd17:             t.vector = 4'b0101;
            5'd18:             t.vector = 4'b0100;
            default:           t.vector = 4'b0000;
        endcase
        return t;
    endfunction

    function automatic logic cmi_expect(input utrap_pkg::mem_ref_t r, input logic dis);
        logic trouble;
        trouble = r.acv | (r.tag_perr != 2'b00) | r.data_perr | (r.hit == 2'b11) |
                  (r.hit == 2'b00);
        return dis | (r.prefetch & trouble);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    task automatic check_trap(input string name, input utrap_pkg::trap_t got,
            input utrap_pkg::trap_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got code %h vector %h, expected code %h vector %h",
                     name, got.code, got.vector, exp.code, exp.vector);
            err_mismatch++;
        end
    endtask

    task automatic check_csr(input string name, input utrap_pkg::csr_data_t got,
            input utrap_pkg::csr_data_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            err_mismatch++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            err_mismatch++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus tasks enter and leave 1 ns after a rising edge
    task automatic send_ref(input utrap_pkg::mem_ref_t r);
        utrap_pkg::trap_t exp;
        logic             done;
        int               t;
        ref_in    = r;
        ref_valid = 1'b1;
        done      = 1'b0;
        for (t = 0; t < TIMEOUT && !done; t++) begin
            @(negedge b_clk);
            done = ref_ready;
            @(posedge b_clk);
            #1;
        end
        ref_valid = 1'b0;
        if (!done) begin
            $display("timeout waiting for ref_ready");
            err_timeout++;
        end else begin
            exp = ref_trap(r, 1'b1, 1'b0);
            if (exp.code != 5'd0) exp_q.push_back(exp);
            if (exp.code == `UTR_TB_ERROR) begin
                if (!m_sum_tb) m_parity = '0;
                m_parity = m_parity | {r.tag_perr, r.data_perr & r.hit[1],
                                       r.data_perr & r.hit[0]};
                m_sum_tb = 1'b1;
            end
            if (exp.code == `UTR_UNALIGN_UB_DATA) m_sum_ub = 1'b1;
            m_last_hit = ^r.hit;
            last_ref   = r;
            @(negedge b_clk);
            check_bit("inhibit_cmi", inhibit_cmi, cmi_expect(r, m_disable));
            if (exp.code == 5'd0) check_bit("ref_ready", ref_ready, 1'b1);
            @(posedge b_clk);
            #1;
        end
    endtask

    task automatic pulse_status(input utrap_pkg::bus_stat_t st);
        logic fail;
        logic wbe;
        fail = (st == `STAT_NONEXIST) || (st == `STAT_UNCORR);
        wbe  = fail & last_ref.write;
        if (fail && !last_ref.write && !last_ref.prefetch)
            exp_q.push_back(ref_trap(last_ref, 1'b0, 1'b1));
        if (st != `STAT_OK) begin
            if (!m_sum_bus) m_bus = '0;
            m_bus = m_bus | {st == `STAT_NONEXIST, st == `STAT_UNCORR, m_sum_bus,
                             st == `STAT_CORR};  // Lost when a log was already pending
            m_sum_bus = 1'b1;
        end
        status       = st;
        status_valid = 1'b1;
        @(posedge b_clk);
        #1;
        status_valid = 1'b0;
        @(negedge b_clk);
        check_bit("write_bus_err", write_bus_err, wbe);
        @(posedge b_clk);
        #1;
    endtask

    task automatic csr_access(input utrap_pkg::csr_addr_t addr, input logic wr,
            input utrap_pkg::csr_data_t wdata);
        csr_in.addr  = addr;
        csr_in.write = wr;
        csr_in.wdata = wdata;
        csr_valid    = 1'b1;
        @(posedge b_clk);
        #1;
        csr_valid = 1'b0;
    endtask

    task automatic read_csr(input utrap_pkg::csr_addr_t addr,
            input utrap_pkg::csr_data_t exp, input string name);
        logic got;
        int   t;
        csr_access(addr, 1'b0, 4'h0);
        got = 1'b0;
        for (t = 0; t < TIMEOUT && !got; t++) begin
            @(negedge b_clk);
            got = rdata_valid;
        end
        if (got) begin
            check_csr(name, rdata, exp);
        end else begin
            $display("timeout waiting for rdata_valid on a %s read", name);
            err_timeout++;
        end
        @(posedge b_clk);
        #1;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while ((exp_q.size() != 0 || trap_valid) && t < TIMEOUT) begin
            @(posedge b_clk);
            #1;
            t++;
        end
        if (exp_q.size() != 0 || trap_valid) begin
            $display("timeout: %0d expected traps were never taken", exp_q.size());
            err_timeout++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock, back-pressure and trap scoreboard
    initial begin
        b_clk = 1'b0;
        forever #2 b_clk = ~b_clk;
    end

    initial begin
        forever begin
            @(posedge b_clk);
            #1;
            stall_state = lcg_step(stall_state);
            trap_ready  = stall_en ? stall_state[16] : 1'b1;
        end
    end

    always @(negedge b_clk) begin
        if (rst_n && trap_valid && trap_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected trap offered with code %h", trap_out.code);
                err_other++;
            end else begin
                check_trap("trap_out", trap_out, exp_q.pop_front());
            end
        end
    end

    initial begin
        utrap_pkg::mem_ref_t r;
        int                  i;
        rst_n        = 1'b0;
        ref_valid    = 1'b0;
        ref_in       = '0;
        trap_ready   = 1'b0;
        status_valid = 1'b0;
        status       = `STAT_OK;
        csr_valid    = 1'b0;
        csr_in       = '0;
        stall_en     = 1'b0;
        rnd_state    = 32'h5d9e;
        stall_state  = lcg_step(32'h5d9e);
        err_mismatch = 0;
        err_timeout  = 0;
        err_other    = 0;
        m_sum_bus    = 1'b0;
        m_sum_tb     = 1'b0;
        m_sum_ub     = 1'b0;
        m_bus        = '0;
        m_parity     = '0;
        m_last_hit   = 1'b0;
        m_disable    = 1'b0;
        last_ref     = '0;
        repeat (2) @(posedge b_clk);
        #1;
        rst_n = 1'b1;
        check_bit("ref_ready", ref_ready, 1'b1);
        check_bit("trap_valid", trap_valid, 1'b0);
        check_bit("write_bus_err", write_bus_err, 1'b0);
        check_bit("rdata_valid", rdata_valid, 1'b0);
        check_bit("inhibit_cmi", inhibit_cmi, 1'b0);

        stall_en = 1'b1;
        for (i = 0; i < NUM_RANDOM; i++) begin
            rnd_state = lcg_step(rnd_state);
            r = utrap_pkg::mem_ref_t'(rnd_state[27:16]);
            if (rnd_state[31:30] == 2'b00)
                r = make_ref(2'b01, 2'b00, 1'b0, 1'b0, 1'b1, rnd_state[29], rnd_state[28],
                             rnd_state[15] ? 3'd4 : 3'd0);  // Clean and sometimes UB unaligned
            send_ref(r);
        end
        send_ref(make_ref(2'b00, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 3'd1));
        send_ref(make_ref(2'b11, 2'b10, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 3'd7));
        send_ref(make_ref(2'b00, 2'b00, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 3'd6));
        send_ref(make_ref(2'b11, 2'b01, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 3'd0));
        wait_drain();

        // A failed read traps and a failed write only interrupts
        send_ref(make_ref(2'b01, 2'b00, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 3'd0));
        pulse_status(`STAT_NONEXIST);
        wait_drain();
        send_ref(make_ref(2'b10, 2'b00, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 3'd0));
        pulse_status(`STAT_UNCORR);
        pulse_status(`STAT_CORR);
        repeat (3) @(posedge b_clk);
        #1;

        read_csr(`CSR_SUMMARY, {m_sum_bus, m_sum_tb, m_sum_ub, 1'b0}, "summary");
        read_csr(`CSR_BUS_ERR, m_bus, "bus_err");
        read_csr(`CSR_PARITY, m_parity, "parity");
        read_csr(`CSR_LAST_HIT, {3'b000, m_last_hit}, "last_hit");
        read_csr(4'd2, 4'h0, "unmapped");

        csr_access(`CSR_SUMMARY, 1'b1, 4'h0);
        repeat (2) @(posedge b_clk);
        #1;
        read_csr(`CSR_SUMMARY, 4'h0, "summary");
        read_csr(`CSR_BUS_ERR, 4'h0, "bus_err");
        read_csr(`CSR_PARITY, 4'h0, "parity");

        csr_access(`CSR_CONFIG, 1'b1, 4'h1);
        m_disable = 1'b1;
        check_bit("inhibit_cmi", inhibit_cmi, 1'b1);
        read_csr(`CSR_CONFIG, 4'h1, "config");
        send_ref(make_ref(2'b01, 2'b00, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 3'd0));
        csr_access(`CSR_CONFIG, 1'b1, 4'h0);
        m_disable = 1'b0;
        check_bit("inhibit_cmi", inhibit_cmi, 1'b0);
        wait_drain();

        $display("errors: mismatch %0d, timeout %0d, protocol %0d",
                 err_mismatch, err_timeout, err_other);
        if (err_mismatch + err_timeout + err_other == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+src
src/utrap_pkg.sv
src/ref_check.sv
src/bus_monitor.sv
src/trap_prio.sv
src/utrap_fsm.sv
src/err_regs.sv
src/utrap_top.sv
test/utrap_assert.sv
test/utrap_tb.sv

//--- run.sh
#!/bin/sh
# Build the utrap testbench with Verilator, run it and scan the log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module utrap_tb \
    -f list.f -o utrap_sim > build.log 2>&1 &&
./obj_dir/utrap_sim > sim.log 2>&1 &&
! grep -q "TEST FAIL" sim.log &&
echo "simulation passed" || { echo "simulation failed, see build.log and sim.log"; exit 1; }
